//--- Makefile
VERILATOR ?= verilator
TOP ?= sdi_debug_tb
FLIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= === FAIL ===

.PHONY: sim clean

# A non-zero exit from the simulator also counts as a failure.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/sdi_command_unit.sv
`timescale 1ns/1ns
`include "sdi_defs.svh"
`default_nettype none

module sdi_command_unit
	import sdi_pkg::*;
(
	input wire iCLOCK,
	input wire reset,
	input wire com_req,
	input wire [7:0] com_cmd,
	input wire [`SDI_DATA_W-1:0] com_data,
	output logic com_busy,
	output logic com_valid,
	output logic com_error,
	output logic [`SDI_DATA_W-1:0] com_rdata,
	input wire req_busy
);
	localparam int IDX_W = $clog2(`SDI_REG_NUM);

	cmd_state_t state;
	logic [7:0] cmd_q;
	logic [`SDI_DATA_W-1:0] data_q;
	logic [`SDI_DATA_W-1:0] rdata_q;
	logic error_q;
	logic [`SDI_DATA_W-1:0] regs [`SDI_REG_NUM];
	sdi_opcode_t opcode;
	logic [IDX_W-1:0] idx;

	assign opcode = sdi_opcode_t'(cmd_q[7:4]);
	assign idx = cmd_q[IDX_W-1:0];

	// Request is taken only from idle.
	always_ff @(posedge iCLOCK) begin
		if (state == CMD_IDLE && com_req) begin
			cmd_q <= com_cmd;
			data_q <= com_data;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (reset) begin
			state <= CMD_IDLE;
			rdata_q <= '0;
			error_q <= 1'b0;
			for (int i = 0; i < `SDI_REG_NUM; i++)
				regs[i] <= '0;
		end else begin
			case (state)
				CMD_IDLE: if (com_req)
					state <= CMD_EXEC;
				CMD_EXEC: begin
					state <= CMD_REPLY;
					case (opcode)
						OP_WRITE: begin
							regs[idx] <= data_q;
							rdata_q <= data_q; // Echo written value.
							error_q <= 1'b0;
						end
						OP_READ: begin
							rdata_q <= regs[idx];
							error_q <= 1'b0;
						end
						default: begin
							rdata_q <= '0;
							error_q <= 1'b1;
						end
					endcase
				end
				CMD_REPLY: if (!req_busy)
					state <= CMD_IDLE; // Reply taken.
				default: state <= CMD_IDLE;
			endcase
		end
	end

	assign com_busy = (state != CMD_IDLE);
	assign com_valid = (state == CMD_REPLY);
	assign com_error = com_valid && error_q;
	assign com_rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/sdi_debug_top.sv
`timescale 1ns/1ns
`include "sdi_defs.svh"
`default_nettype none

module sdi_debug_top
	import sdi_pkg::*;
(
	input wire iCLOCK,
	input wire reset,
	input wire if_select,
	input wire uart_rxd,
	output wire uart_txd,
	input wire para_req,
	input wire [7:0] para_cmd,
	input wire [`SDI_DATA_W-1:0] para_data,
	output wire para_busy,
	output wire para_valid,
	output wire para_error,
	output wire [`SDI_DATA_W-1:0] para_rdata,
	input wire para_ready_busy
);
	wire uart_req;
	wire [7:0] uart_cmd;
	wire [`SDI_DATA_W-1:0] uart_data;
	wire uart_busy;
	wire uart_valid;
	wire uart_error;
	wire [`SDI_DATA_W-1:0] uart_rdata;
	wire uart_ready_busy;
	wire com_req;
	wire [7:0] com_cmd;
	wire [`SDI_DATA_W-1:0] com_data;
	wire req_busy;
	wire com_busy;
	wire com_valid;
	wire com_error;
	wire [`SDI_DATA_W-1:0] com_rdata;

	sdi_uart_link i_sdi_uart_link (
		.iCLOCK(iCLOCK), .reset(reset),
		.uart_rxd(uart_rxd), .uart_txd(uart_txd),
		.req(uart_req), .cmd(uart_cmd), .data(uart_data),
		.busy_in(uart_busy), .valid(uart_valid), .error(uart_error),
		.rdata(uart_rdata), .ready_busy(uart_ready_busy)
	);

	sdi_interface_control i_sdi_interface_control (
		.iCLOCK(iCLOCK), .reset(reset), .if_select(if_select),
		.para_req(para_req), .para_cmd(para_cmd), .para_data(para_data),
		.para_busy(para_busy), .para_valid(para_valid), .para_error(para_error),
		.para_rdata(para_rdata), .para_ready_busy(para_ready_busy),
		.uart_req(uart_req), .uart_cmd(uart_cmd), .uart_data(uart_data),
		.uart_busy(uart_busy), .uart_valid(uart_valid), .uart_error(uart_error),
		.uart_rdata(uart_rdata), .uart_ready_busy(uart_ready_busy),
		.com_req(com_req), .com_cmd(com_cmd), .com_data(com_data),
		.req_busy(req_busy), .com_busy(com_busy), .com_valid(com_valid),
		.com_error(com_error), .com_rdata(com_rdata)
	);

	sdi_command_unit i_sdi_command_unit (
		.iCLOCK(iCLOCK), .reset(reset),
		.com_req(com_req), .com_cmd(com_cmd), .com_data(com_data),
		.com_busy(com_busy), .com_valid(com_valid), .com_error(com_error),
		.com_rdata(com_rdata), .req_busy(req_busy)
	);

endmodule

`default_nettype wire

//--- design/sdi_defs.svh
`ifndef SDI_DEFS_SVH
`define SDI_DEFS_SVH

`default_nettype none

// Width of command data and of each debug register.
`define SDI_DATA_W 32

// Number of debug registers behind the command bus.
`define SDI_REG_NUM 16

// Clocks per UART bit.
`define SDI_UART_DIV 8

// Status byte sent back for an undefined opcode.
`define SDI_ERR_CODE 8'hEE

`default_nettype wire

`endif

//--- design/sdi_interface_control.sv
`timescale 1ns/1ns
`include "sdi_defs.svh"
`default_nettype none

module sdi_interface_control
	import sdi_pkg::*;
(
	input wire iCLOCK,
	input wire reset,
	input wire if_select,
	input wire para_req,
	input wire [7:0] para_cmd,
	input wire [`SDI_DATA_W-1:0] para_data,
	output logic para_busy,
	output logic para_valid,
	output logic para_error,
	output logic [`SDI_DATA_W-1:0] para_rdata,
	input wire para_ready_busy,
	input wire uart_req,
	input wire [7:0] uart_cmd,
	input wire [`SDI_DATA_W-1:0] uart_data,
	output logic uart_busy,
	output logic uart_valid,
	output logic uart_error,
	output logic [`SDI_DATA_W-1:0] uart_rdata,
	input wire uart_ready_busy,
	output logic com_req,
	output logic [7:0] com_cmd,
	output logic [`SDI_DATA_W-1:0] com_data,
	output logic req_busy,
	input wire com_busy,
	input wire com_valid,
	input wire com_error,
	input wire [`SDI_DATA_W-1:0] com_rdata
);
	logic sel_q; // 1 is parallel, 0 is UART.

	always_ff @(posedge iCLOCK) begin
		if (reset)
			sel_q <= 1'b0;
		else if (!com_busy && !com_req)
			sel_q <= if_select; // Only with no command in flight.
	end

	always_comb begin
		com_req = sel_q ? para_req : uart_req;
		com_cmd = sel_q ? para_cmd : uart_cmd;
		com_data = sel_q ? para_data : uart_data;
		req_busy = sel_q ? para_ready_busy : uart_ready_busy;
	end

	// Unselected side is held off with busy high.
	always_comb begin
		para_busy = sel_q ? com_busy : 1'b1;
		para_valid = sel_q ? com_valid : 1'b0;
		para_error = sel_q ? com_error : 1'b0;
		para_rdata = sel_q ? com_rdata : '0;
		uart_busy = sel_q ? 1'b1 : com_busy;
		uart_valid = sel_q ? 1'b0 : com_valid;
		uart_error = sel_q ? 1'b0 : com_error;
		uart_rdata = sel_q ? '0 : com_rdata;
	end

endmodule

`default_nettype wire

//--- design/sdi_pkg.sv
`default_nettype none

package sdi_pkg;

	// Command byte bits 7:4. Any other value gives an error reply.
	typedef enum logic [3:0] {
		OP_WRITE = 4'd1,
		OP_READ  = 4'd2
	} sdi_opcode_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		BITS,
		STOP
	} uart_state_t;

	typedef enum logic [1:0] {
		CMD_IDLE,
		CMD_EXEC,
		CMD_REPLY
	} cmd_state_t;

endpackage

`default_nettype wire

//--- design/sdi_uart_link.sv
`timescale 1ns/1ns
`include "sdi_defs.svh"
`default_nettype none

module sdi_uart_link
	import sdi_pkg::*;
(
	input wire iCLOCK,
	input wire reset,
	input wire uart_rxd,
	output logic uart_txd,
	output logic req,
	output logic [7:0] cmd,
	output logic [`SDI_DATA_W-1:0] data,
	input wire busy_in,
	input wire valid,
	input wire error,
	input wire [`SDI_DATA_W-1:0] rdata,
	output logic ready_busy
);
	localparam int CNT_W = $clog2(`SDI_UART_DIV) + 1;
	localparam int NBYTES = `SDI_DATA_W / 8 + 1;
	localparam int FRAME_W = `SDI_DATA_W + 8;

	logic [1:0] rxd_sync;
	uart_state_t rx_state;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0] rx_bit;
	logic [7:0] rx_sh;
	logic [2:0] rx_byte;
	logic pend;

	uart_state_t tx_state;
	logic [CNT_W-1:0] tx_cnt;
	logic [2:0] tx_bit;
	logic [2:0] tx_byte;
	logic [FRAME_W-1:0] tx_frame;

	always_ff @(posedge iCLOCK) begin
		if (reset)
			rxd_sync <= 2'b11;
		else
			rxd_sync <= {rxd_sync[0], uart_rxd};
	end

	always_ff @(posedge iCLOCK) begin
		if (reset) begin
			rx_state <= IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_byte <= '0;
			pend <= 1'b0;
			req <= 1'b0;
		end else begin
			req <= 1'b0;
			if (pend && !busy_in && !req) begin
				req <= 1'b1; // One-cycle request pulse.
				pend <= 1'b0;
			end
			case (rx_state)
				IDLE: begin
					rx_cnt <= '0;
					if (!rxd_sync[1])
						rx_state <= START;
				end
				START: begin
					rx_cnt <= rx_cnt + 1'b1;
					if (rx_cnt == CNT_W'(`SDI_UART_DIV / 2 - 1)) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						rx_state <= rxd_sync[1] ? IDLE : BITS; // Glitch, not a start bit.
					end
				end
				BITS: begin
					rx_cnt <= rx_cnt + 1'b1;
					if (rx_cnt == CNT_W'(`SDI_UART_DIV - 1)) begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= STOP;
					end
				end
				STOP: begin
					rx_cnt <= rx_cnt + 1'b1;
					if (rx_cnt == CNT_W'(`SDI_UART_DIV - 1)) begin
						rx_state <= IDLE;
						if (rx_byte == 3'(NBYTES - 1)) begin
							rx_byte <= '0;
							pend <= 1'b1;
						end else begin
							rx_byte <= rx_byte + 1'b1;
						end
					end
				end
				default: rx_state <= IDLE;
			endcase
		end
	end

	// Byte assembly, command first and data most significant byte first.
	always_ff @(posedge iCLOCK) begin
		if (rx_state == BITS && rx_cnt == CNT_W'(`SDI_UART_DIV - 1))
			rx_sh <= {rxd_sync[1], rx_sh[7:1]};
		if (rx_state == STOP && rx_cnt == CNT_W'(`SDI_UART_DIV - 1)) begin
			if (rx_byte == 3'd0)
				cmd <= rx_sh;
			else
				data <= {data[`SDI_DATA_W-9:0], rx_sh};
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (reset) begin
			tx_state <= IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
			tx_byte <= '0;
		end else begin
			tx_cnt <= tx_cnt + 1'b1;
			case (tx_state)
				IDLE: begin
					tx_cnt <= '0;
					tx_byte <= '0;
					if (valid && !ready_busy)
						tx_state <= START; // Reply latched here.
				end
				START: if (tx_cnt == CNT_W'(`SDI_UART_DIV - 1)) begin
					tx_cnt <= '0;
					tx_bit <= '0;
					tx_state <= BITS;
				end
				BITS: if (tx_cnt == CNT_W'(`SDI_UART_DIV - 1)) begin
					tx_cnt <= '0;
					tx_bit <= tx_bit + 1'b1;
					if (tx_bit == 3'd7)
						tx_state <= STOP;
				end
				STOP: if (tx_cnt == CNT_W'(`SDI_UART_DIV - 1)) begin
					tx_cnt <= '0;
					tx_byte <= tx_byte + 1'b1;
					tx_state <= (tx_byte == 3'(NBYTES - 1)) ? IDLE : START;
				end
				default: tx_state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (tx_state == IDLE && valid && !ready_busy)
			tx_frame <= {error ? `SDI_ERR_CODE : 8'h00, rdata};
		else if (tx_state == STOP && tx_cnt == CNT_W'(`SDI_UART_DIV - 1))
			tx_frame <= tx_frame << 8; // Next byte to the top.
	end

	always_comb begin
		case (tx_state)
			START: uart_txd = 1'b0;
			BITS: uart_txd = tx_frame[FRAME_W - 8 + int'(tx_bit)];
			default: uart_txd = 1'b1;
		endcase
	end

	assign ready_busy = (tx_state != IDLE);

endmodule

`default_nettype wire

//--- tests/sdi_debug_chk.sv
`timescale 1ns/1ns
`include "sdi_defs.svh"
`default_nettype none

module sdi_debug_chk
	import sdi_pkg::*;
(
	input wire iCLOCK,
	input wire reset,
	input wire com_req,
	input wire com_busy,
	input wire com_valid,
	input wire com_error,
	input wire [`SDI_DATA_W-1:0] com_rdata,
	input wire req_busy
);

	// Busy on the next cycle, valid with busy on the one after.
	req_to_valid: assert property (@(posedge iCLOCK) disable iff (reset)
		com_req && !com_busy |=> (com_busy && !com_valid) ##1 (com_busy && com_valid))
		else $error("reply did not follow an accepted request by two cycles");

	// Requesters must wait for busy low.
	no_req_when_busy: assert property (@(posedge iCLOCK) disable iff (reset)
		com_req |-> !com_busy)
		else $error("request raised while the command unit is busy");

	reply_held: assert property (@(posedge iCLOCK) disable iff (reset)
		com_valid && req_busy |=> com_valid && $stable(com_error) && $stable(com_rdata))
		else $error("reply changed under back-pressure");

endmodule

bind sdi_command_unit sdi_debug_chk i_sdi_debug_chk (
	.iCLOCK(iCLOCK), .reset(reset), .com_req(com_req), .com_busy(com_busy),
	.com_valid(com_valid), .com_error(com_error), .com_rdata(com_rdata),
	.req_busy(req_busy)
);

`default_nettype wire

//--- tests/sdi_debug_tb.sv
`timescale 1ns/1ns
`include "sdi_defs.svh"
`default_nettype none

module sdi_debug_tb;
	logic iCLOCK;
	logic reset;
	logic if_select;
	logic uart_rxd;
	wire uart_txd;
	logic para_req;
	logic [7:0] para_cmd;
	logic [`SDI_DATA_W-1:0] para_data;
	wire para_busy;
	wire para_valid;
	wire para_error;
	wire [`SDI_DATA_W-1:0] para_rdata;
	logic para_ready_busy;

	integer seed;
	logic para_mode;
	logic [3:0] idx;
	logic [3:0] bad_op;
	logic [`SDI_DATA_W-1:0] wdata;
	logic [`SDI_DATA_W-1:0] model_regs [`SDI_REG_NUM];
	logic [`SDI_DATA_W:0] para_exp_q [$]; // {error, data}.
	logic [`SDI_DATA_W+7:0] uart_exp_q [$]; // {status, data}.
	logic [`SDI_DATA_W+7:0] uart_got_q [$];
	logic [`SDI_DATA_W:0] para_exp;
	logic [`SDI_DATA_W+7:0] uart_exp;
	logic [`SDI_DATA_W+7:0] uart_got;

	sdi_debug_top i_sdi_debug_top (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	// Opcode 1 writes, 2 reads, anything else is an error reply.
	function automatic logic [`SDI_DATA_W:0] model_reply(input logic [7:0] cmd,
		input logic [`SDI_DATA_W-1:0] data);
		logic [`SDI_DATA_W:0] r;
		if (cmd[7:4] == 4'd1) begin
			model_regs[cmd[3:0]] = data;
			r = {1'b0, data};
		end else if (cmd[7:4] == 4'd2) begin
			r = {1'b0, model_regs[cmd[3:0]]};
		end else begin
			r = {1'b1, {`SDI_DATA_W{1'b0}}};
		end
		return r;
	endfunction

	task automatic stop_with_failure(input string what);
		$display("Error: %s", what);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic wait_para_idle();
		int n;
		n = 0;
		while (para_busy) begin
			@(negedge iCLOCK);
			n++;
			if (n > 50)
				stop_with_failure("timeout waiting for para_busy to fall");
		end
	endtask

	task automatic para_command(input logic [7:0] cmd, input logic [`SDI_DATA_W-1:0] data,
		input int hold);
		int lat;
		logic [`SDI_DATA_W:0] first;
		wait_para_idle();
		para_exp_q.push_back(model_reply(cmd, data));
		para_req = 1'b1;
		para_cmd = cmd;
		para_data = data;
		para_ready_busy = (hold > 0);
		lat = 0;
		do begin
			@(negedge iCLOCK);
			para_req = 1'b0;
			lat++;
			if (lat > 20)
				stop_with_failure("timeout waiting for para_valid");
		end while (!para_valid);
		compare_value("para latency", 64'(lat), 64'd2);
		first = {para_error, para_rdata};
		for (int i = 0; i < hold; i++) begin
			@(negedge iCLOCK);
			compare_value("para_valid", 64'(para_valid), 64'd1);
			compare_value("para held reply", 64'({para_error, para_rdata}), 64'(first));
		end
		para_ready_busy = 1'b0;
		@(negedge iCLOCK);
	endtask

	task automatic read_all_registers();
		for (int i = 0; i < `SDI_REG_NUM; i++)
			para_command({4'd2, 4'(i)}, '0, 0);
	endtask

	task automatic send_uart_byte(input logic [7:0] b);
		logic [9:0] fr;
		fr = {1'b1, b, 1'b0}; // Stop, data LSB first, start.
		for (int i = 0; i < 10; i++) begin
			uart_rxd = fr[0];
			fr = fr >> 1;
			repeat (`SDI_UART_DIV) @(negedge iCLOCK);
		end
	endtask

	task automatic recv_uart_byte(output logic [7:0] b);
		int n;
		n = 0;
		while (uart_txd) begin
			@(negedge iCLOCK);
			n++;
			if (n > 1000)
				stop_with_failure("timeout waiting for a UART start bit");
		end
		repeat (`SDI_UART_DIV / 2) @(negedge iCLOCK); // Middle of the start bit.
		for (int i = 0; i < 8; i++) begin
			repeat (`SDI_UART_DIV) @(negedge iCLOCK);
			b = {uart_txd, b[7:1]};
		end
		repeat (`SDI_UART_DIV) @(negedge iCLOCK);
		compare_value("uart_txd stop bit", 64'(uart_txd), 64'd1);
	endtask

	task automatic uart_command(input logic [7:0] cmd, input logic [`SDI_DATA_W-1:0] data);
		logic [`SDI_DATA_W:0] rep;
		logic [7:0] rx_b;
		logic [`SDI_DATA_W+7:0] frame;
		rep = model_reply(cmd, data);
		uart_exp_q.push_back({rep[`SDI_DATA_W] ? `SDI_ERR_CODE : 8'h00, rep[`SDI_DATA_W-1:0]});
		fork
			begin
				send_uart_byte(cmd);
				for (int i = `SDI_DATA_W / 8 - 1; i >= 0; i--)
					send_uart_byte(data[8*i +: 8]);
			end
			begin
				for (int i = 0; i < `SDI_DATA_W / 8 + 1; i++) begin
					recv_uart_byte(rx_b);
					frame = {frame[`SDI_DATA_W-1:0], rx_b};
				end
				uart_got_q.push_back(frame);
			end
		join
	endtask

	task automatic wait_checks_done();
		int n;
		n = 0;
		while (para_exp_q.size() != 0 || uart_exp_q.size() != 0) begin
			@(negedge iCLOCK);
			n++;
			if (n > 20)
				stop_with_failure("replies still outstanding at the end of the test");
		end
	endtask

	// Reply taken on this edge.
	always @(posedge iCLOCK) begin
		if (!reset && para_valid && !para_ready_busy) begin
			if (para_exp_q.size() == 0)
				stop_with_failure("parallel reply with no command pending");
			para_exp = para_exp_q.pop_front();
			compare_value("para_error", 64'(para_error), 64'(para_exp[`SDI_DATA_W]));
			compare_value("para_rdata", 64'(para_rdata), 64'(para_exp[`SDI_DATA_W-1:0]));
		end
		if (uart_got_q.size() != 0) begin
			uart_got = uart_got_q.pop_front();
			uart_exp = uart_exp_q.pop_front();
			compare_value("uart status", 64'(uart_got[`SDI_DATA_W+7:`SDI_DATA_W]),
				64'(uart_exp[`SDI_DATA_W+7:`SDI_DATA_W]));
			compare_value("uart data", 64'(uart_got[`SDI_DATA_W-1:0]),
				64'(uart_exp[`SDI_DATA_W-1:0]));
		end
		if (para_mode)
			compare_value("uart_txd", 64'(uart_txd), 64'd1); // Link idle while deselected.
	end

	initial begin
		seed = 3735;
		reset = 1'b1;
		if_select = 1'b0;
		uart_rxd = 1'b1;
		para_req = 1'b0;
		para_cmd = '0;
		para_data = '0;
		para_ready_busy = 1'b0;
		para_mode = 1'b0;
		for (int i = 0; i < `SDI_REG_NUM; i++)
			model_regs[i] = '0;
		repeat (8) @(negedge iCLOCK);
		reset = 1'b0;
		@(negedge iCLOCK);
		compare_value("uart_txd", 64'(uart_txd), 64'd1);
		compare_value("para_busy", 64'(para_busy), 64'd1); // UART owns the bus.

		wdata = $random(seed);
		uart_command({4'd1, 4'd5}, wdata);
		uart_command({4'd2, 4'd5}, '0);
		uart_command({4'd2, 4'd0}, '0);
		wdata = $random(seed);
		uart_command({4'd9, 4'd3}, wdata);

		if_select = 1'b1;
		para_mode = 1'b1;
		wait_para_idle();

		repeat (24) begin
			idx = 4'($random(seed));
			wdata = $random(seed);
			para_command({4'd1, idx}, wdata, 0);
		end
		read_all_registers();

		repeat (6) begin
			bad_op = 4'(3 + ($random(seed) & 7));
			idx = 4'($random(seed));
			wdata = $random(seed);
			para_command({bad_op, idx}, wdata, 0);
		end
		read_all_registers();

		repeat (6) begin
			idx = 4'($random(seed));
			wdata = $random(seed);
			para_command({4'd1, idx}, wdata, 1 + ($random(seed) & 15));
			para_command({4'd2, idx}, '0, 1 + ($random(seed) & 15));
		end

		wait_checks_done();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/sdi_pkg.sv
design/sdi_uart_link.sv
design/sdi_interface_control.sv
design/sdi_command_unit.sv
design/sdi_debug_top.sv
tests/sdi_debug_chk.sv
tests/sdi_debug_tb.sv
